/* vlog.f */
source/wb_pkg.sv
source/platform_pkg.sv
source/wb_interconnect.sv
source/mtimer.sv
source/led_driver.sv
source/yarc_platform.sv
dv/dmem_model.sv
dv/yarc_platform_tb.sv

/* run.sh */
#!/bin/sh
# build and run the platform testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --timescale 1ns/100ps \
    --top-module yarc_platform_tb \
    -f vlog.f \
    -o sim_yarc_platform

./obj_dir/sim_yarc_platform > sim.log 2>&1
cat sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "simulation reported errors"
    exit 1
fi
echo "simulation clean"

/* dv/yarc_platform_tb.sv */
// testbench for the platform that plays the core on the master port
// directed led, dmem, timer and unmapped checks followed by a random mix
// every response is checked against a shadow model of the slaves
module yarc_platform_tb
    import wb_pkg::*;
    import platform_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] DMEM_BASE  = START_ADDRESS[DMEM_SLAVE_INDEX];
    localparam logic [31:0] TIMER_BASE = START_ADDRESS[MTIMER_SLAVE_INDEX];
    localparam logic [31:0] LED_BASE   = START_ADDRESS[LED_DRIVER_SLAVE_INDEX];
    localparam logic [31:0] MTIME_LO   = TIMER_BASE | {28'h0, MTIME_LO_OFFSET};
    localparam logic [31:0] MTIME_HI   = TIMER_BASE | {28'h0, MTIME_HI_OFFSET};
    localparam logic [31:0] CMP_LO     = TIMER_BASE | {28'h0, MTIMECMP_LO_OFFSET};
    localparam logic [31:0] CMP_HI     = TIMER_BASE | {28'h0, MTIMECMP_HI_OFFSET};
    // addresses just outside the windows and far corners
    localparam logic [31:0] UNMAPPED [6] = '{32'h0001_4000, 32'h0003_0004, 32'h0002_0010,
                                             32'h0000_fffc, 32'h0000_0000, 32'hffff_fffc};

    // one finished transfer as queued for the compare process
    typedef struct packed {
        logic [31:0] addr;
        logic        got_ack;
        logic        got_err;
        logic [31:0] rdata;
        logic        exp_err;
        logic        chk_data;
        logic [31:0] exp_data;
    } rsp_t;

    logic clk_i, arst_n_i, cyc_i, stb_i, we_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [SEL_WIDTH-1:0]  sel_i;
    logic [DATA_WIDTH-1:0] wdata_i, rdata_o, dmem_wdata_o, dmem_rdata_i;
    logic ack_o, err_o, dmem_cyc_o, dmem_stb_o, dmem_we_o, dmem_ack_i, timer_irq_o;
    logic [ADDR_WIDTH-1:0] dmem_addr_o;
    logic [SEL_WIDTH-1:0]  dmem_sel_o;
    logic [7:0]            led_status_o;

    // shadow state of the slaves
    logic [31:0] shadow_mem [4096];
    logic [7:0]  shadow_led;
    logic [63:0] shadow_cmp;

    rsp_t        rsp_q [$];
    logic        unmapped_active;
    int          check_errors, other_errors, transfers, cnt;
    logic [31:0] rnd, a, rd;
    logic [63:0] prev_time, now_time, target;

    yarc_platform DUT (.*);

    dmem_model dmem_model_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cyc_i    (dmem_cyc_o),
        .stb_i    (dmem_stb_o),
        .we_i     (dmem_we_o),
        .addr_i   (dmem_addr_o),
        .sel_i    (dmem_sel_o),
        .wdata_i  (dmem_wdata_o),
        .ack_o    (dmem_ack_i),
        .rdata_o  (dmem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic report_mismatch(input logic [31:0] at, input string name,
                                   input logic [63:0] exp_v, input logic [63:0] act_v);
        $display("CHECK FAILED time=%0t addr=%h signal=%s expected=%h actual=%h",
                 $time, at, name, exp_v, act_v);
        check_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR time=%0t %s", $time, what);
        other_errors++;
    endtask

    // window index per the memory map or -1 when unmapped
    function automatic int decode_region(input logic [31:0] at);
        int hit;
        hit = -1;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if ((at & MASK[i]) == START_ADDRESS[i]) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] new_w, input logic [3:0] s);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // reference model giving response kind and read data from the shadow state
    function automatic void expected_response(input logic [31:0] at, input logic w,
            output logic exp_err, output logic chk_data, output logic [31:0] exp_data);
        int region;
        region = decode_region(at);
        exp_err = region < 0;
        chk_data = 1'b0;
        exp_data = '0;
        if (!w && region == DMEM_SLAVE_INDEX) begin
            chk_data = 1'b1;
            exp_data = shadow_mem[at[13:2]];
        end else if (!w && region == LED_DRIVER_SLAVE_INDEX) begin
            chk_data = 1'b1;
            exp_data = {24'h0, shadow_led};
        end else if (!w && region == MTIMER_SLAVE_INDEX && at[3]) begin
            // mtime moves on its own so only mtimecmp is predictable
            chk_data = 1'b1;
            exp_data = at[2] ? shadow_cmp[63:32] : shadow_cmp[31:0];
        end
    endfunction

    function automatic void apply_write(input logic [31:0] at, input logic [3:0] s,
                                        input logic [31:0] d);
        int region;
        region = decode_region(at);
        if (region == DMEM_SLAVE_INDEX) begin
            shadow_mem[at[13:2]] = merge_lanes(shadow_mem[at[13:2]], d, s);
        end else if (region == LED_DRIVER_SLAVE_INDEX && s[0]) begin
            shadow_led = d[7:0];
        end else if (region == MTIMER_SLAVE_INDEX && at[3:2] == MTIMECMP_LO_OFFSET[3:2]) begin
            shadow_cmp[31:0] = merge_lanes(shadow_cmp[31:0], d, s);
        end else if (region == MTIMER_SLAVE_INDEX && at[3:2] == MTIMECMP_HI_OFFSET[3:2]) begin
            shadow_cmp[63:32] = merge_lanes(shadow_cmp[63:32], d, s);
        end
    endfunction

    // one bus transfer that starts on a falling edge and waits for ack or err
    task automatic bus_transfer(input logic [31:0] at, input logic w, input logic [3:0] s,
                                input logic [31:0] d, output logic [31:0] rd_data);
        rsp_t        r;
        int          cycles;
        int          region;
        logic        exp_err;
        logic        chk_data;
        logic [31:0] exp_data;
        region = decode_region(at);
        expected_response(at, w, exp_err, chk_data, exp_data);
        r = '0;
        r.addr = at;
        r.exp_err = exp_err;
        r.chk_data = chk_data;
        r.exp_data = exp_data;
        @(negedge clk_i);
        addr_i = at;
        we_i = w;
        sel_i = s;
        wdata_i = d;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        unmapped_active = region < 0;
        cycles = 0;
        while (!r.got_ack && !r.got_err && cycles < 50) begin
            @(negedge clk_i);
            r.got_ack = ack_o;
            r.got_err = err_o;
            r.rdata = rdata_o;
            cycles++;
        end
        cyc_i = 1'b0;
        stb_i = 1'b0;
        unmapped_active = 1'b0;
        rd_data = r.rdata;
        transfers++;
        if (!r.got_ack && !r.got_err) begin
            report_problem($sformatf("no ack or err within 50 cycles for addr %h", at));
        end else begin
            if (r.got_ack && r.got_err) begin
                report_problem($sformatf("ack and err both high for addr %h", at));
            end
            // everything except dmem answers one cycle after stb
            if (region != DMEM_SLAVE_INDEX && cycles != 1) begin
                report_mismatch(at, "latency", 64'd1, 64'(cycles));
            end
            rsp_q.push_back(r);
            if (w && !exp_err) begin
                apply_write(at, s, d);
            end
            if (led_status_o != shadow_led) begin
                report_mismatch(at, "led_status_o", 64'(shadow_led), 64'(led_status_o));
            end
        end
    endtask

    // 64-bit mtime with the high word read again until it holds still
    task automatic read_mtime(output logic [63:0] value);
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] hi_again;
        int          tries;
        bus_transfer(MTIME_HI, 1'b0, 4'hf, '0, hi);
        bus_transfer(MTIME_LO, 1'b0, 4'hf, '0, lo);
        bus_transfer(MTIME_HI, 1'b0, 4'hf, '0, hi_again);
        tries = 0;
        while (hi_again != hi && tries < 4) begin
            hi = hi_again;
            bus_transfer(MTIME_LO, 1'b0, 4'hf, '0, lo);
            bus_transfer(MTIME_HI, 1'b0, 4'hf, '0, hi_again);
            tries++;
        end
        if (hi_again != hi) begin
            report_problem("mtime high word kept changing");
        end
        value = {hi_again, lo};
    endtask

    task automatic check_response(input rsp_t r);
        if (r.got_ack != !r.exp_err) begin
            report_mismatch(r.addr, "ack_o", 64'(!r.exp_err), 64'(r.got_ack));
        end
        if (r.got_err != r.exp_err) begin
            report_mismatch(r.addr, "err_o", 64'(r.exp_err), 64'(r.got_err));
        end
        if (r.chk_data && r.got_ack && r.rdata != r.exp_data) begin
            report_mismatch(r.addr, "rdata_o", 64'(r.exp_data), 64'(r.rdata));
        end
    endtask

    // compare process draining what the master queued on the falling edge
    always @(posedge clk_i) begin
        while (rsp_q.size() > 0) begin
            check_response(rsp_q.pop_front());
        end
    end

    // unmapped requests must never reach the dmem port
    always @(posedge clk_i) begin
        if (unmapped_active && dmem_stb_o) begin
            report_problem($sformatf("dmem_stb_o raised for unmapped addr %h", addr_i));
        end
        if (unmapped_active && dmem_cyc_o) begin
            report_problem($sformatf("dmem_cyc_o raised for unmapped addr %h", addr_i));
        end
    end

    initial begin
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i = 1'b0;
        addr_i = '0;
        sel_i = '0;
        wdata_i = '0;
        arst_n_i = 1'b0;
        unmapped_active = 1'b0;
        void'($urandom(32'hc56b5b23));
        for (int i = 0; i < 4096; i++) begin
            shadow_mem[i] = {8'hd0, i[11:0], ~i[11:0]};
        end
        shadow_led = '0;
        shadow_cmp = '1;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // reset values
        if (ack_o != 1'b0) report_mismatch('0, "ack_o", 64'd0, 64'(ack_o));
        if (err_o != 1'b0) report_mismatch('0, "err_o", 64'd0, 64'(err_o));
        if (led_status_o != 8'h0) report_mismatch('0, "led_status_o", 64'd0, 64'(led_status_o));
        if (timer_irq_o != 1'b0) report_mismatch('0, "timer_irq_o", 64'd0, 64'(timer_irq_o));

        // led register where only lane 0 counts
        bus_transfer(LED_BASE, 1'b1, 4'b0001, 32'h0000_00a5, rd);
        bus_transfer(LED_BASE, 1'b1, 4'b1110, 32'h1234_563c, rd);
        bus_transfer(LED_BASE, 1'b0, 4'b1111, '0, rd);
        bus_transfer(LED_BASE, 1'b1, 4'b1111, 32'hffff_ff5a, rd);
        bus_transfer(LED_BASE, 1'b0, 4'b0001, '0, rd);

        // dmem with half of the accesses on 16 words so reads hit earlier writes
        for (int n = 0; n < 60; n++) begin
            rnd = $urandom();
            a = DMEM_BASE | {18'h0, rnd[30] ? rnd[13:2] : {8'h0, rnd[5:2]}, 2'b00};
            bus_transfer(a, rnd[31], rnd[27:24], $urandom(), rd);
        end

        // mtime strictly increasing and ignoring writes
        read_mtime(prev_time);
        for (int n = 0; n < 5; n++) begin
            read_mtime(now_time);
            if (now_time <= prev_time) report_problem("mtime did not increase");
            prev_time = now_time;
        end
        bus_transfer(MTIME_LO, 1'b1, 4'hf, '0, rd);
        bus_transfer(MTIME_HI, 1'b1, 4'hf, '0, rd);
        read_mtime(now_time);
        if (now_time <= prev_time) report_problem("mtime went back after a write");

        // timer interrupt with the low word first so the compare never passes early
        read_mtime(now_time);
        target = now_time + 64'd200;
        bus_transfer(CMP_LO, 1'b1, 4'hf, target[31:0], rd);
        bus_transfer(CMP_HI, 1'b1, 4'hf, target[63:32], rd);
        if (timer_irq_o != 1'b0) report_mismatch(CMP_HI, "timer_irq_o", 64'd0, 64'(timer_irq_o));
        cnt = 0;
        while (!timer_irq_o && cnt < 400) begin
            @(negedge clk_i);
            cnt++;
        end
        if (!timer_irq_o) report_problem("timer_irq_o did not rise within 400 cycles");
        bus_transfer(CMP_HI, 1'b1, 4'hf, 32'hffff_ffff, rd);
        cnt = 0;
        while (timer_irq_o && cnt < 3) begin
            @(negedge clk_i);
            cnt++;
        end
        if (timer_irq_o) report_problem("timer_irq_o still high 3 cycles after clearing");
        bus_transfer(CMP_LO, 1'b1, 4'b0100, 32'h0012_3400, rd);
        bus_transfer(CMP_LO, 1'b0, 4'hf, '0, rd);
        bus_transfer(CMP_LO, 1'b1, 4'hf, 32'hffff_ffff, rd);
        bus_transfer(CMP_LO, 1'b0, 4'hf, '0, rd);
        bus_transfer(CMP_HI, 1'b0, 4'hf, '0, rd);

        // unmapped space and then the dmem words an alias would have hit
        for (int n = 0; n < 6; n++) begin
            bus_transfer(UNMAPPED[n], 1'b1, 4'hf, $urandom(), rd);
            bus_transfer(UNMAPPED[n], 1'b0, 4'hf, '0, rd);
        end
        bus_transfer(DMEM_BASE, 1'b0, 4'hf, '0, rd);
        bus_transfer(DMEM_BASE | 32'h0000_3ffc, 1'b0, 4'hf, '0, rd);

        // random mix over all windows and unmapped space
        for (int n = 0; n < 300; n++) begin
            rnd = $urandom();
            case (rnd[2:0])
                3'd0, 3'd1, 3'd2: a = DMEM_BASE | {18'h0, rnd[15:4], 2'b00};
                3'd3:             a = TIMER_BASE | {28'h0, rnd[5:4], 2'b00};
                3'd4:             a = LED_BASE;
                default:          a = $urandom();
            endcase
            bus_transfer(a, rnd[31], rnd[27:24], $urandom(), rd);
        end

        // let the compare process drain
        cnt = 0;
        while (rsp_q.size() > 0 && cnt < 10) begin
            @(negedge clk_i);
            cnt++;
        end
        if (rsp_q.size() > 0) report_problem("responses left unchecked at the end");

        $display("transfers=%0d check_errors=%0d other_errors=%0d",
                 transfers, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : yarc_platform_tb

/* dv/dmem_model.sv */
// data memory behind the platform dmem port, testbench only
// 16 KiB of words, acks each request after a random wait
module dmem_model
    import wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [SEL_WIDTH-1:0]  sel_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic                  ack_o,
    output logic [DATA_WIDTH-1:0] rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_WIDTH-1:0] mem [4096];
    logic [11:0]           word;
    logic [1:0]            wait_cnt;
    logic                  busy;

    // word index inside the 16 KiB window
    assign word = addr_i[13:2];

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o    <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= '0;
            rdata_o  <= '0;
            // contents follow the word index, shadow copy starts from the same pattern
            for (int i = 0; i < 4096; i++) begin
                mem[i] <= {8'hd0, i[11:0], ~i[11:0]};
            end
        end else begin
            ack_o <= 1'b0;
            if (cyc_i && stb_i && !busy && !ack_o) begin
                // new request, 0 to 3 extra wait cycles
                busy     <= 1'b1;
                wait_cnt <= 2'($urandom_range(3, 0));
            end else if (busy && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (busy) begin
                // single cycle ack, data and write land on the same edge
                busy    <= 1'b0;
                ack_o   <= 1'b1;
                rdata_o <= mem[word];
                if (we_i) begin
                    for (int b = 0; b < SEL_WIDTH; b++) begin
                        if (sel_i[b]) begin
                            mem[word][b*8 +: 8] <= wdata_i[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule : dmem_model

/* source/yarc_platform.sv */
// peripheral side of the platform, the core drives the master port
// connects the interconnect to the timer, the led register and the dmem port
module yarc_platform
    import wb_pkg::*;
    import platform_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // master port from the core load/store unit
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [SEL_WIDTH-1:0]  sel_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic                  ack_o,
    output logic                  err_o,
    output logic [DATA_WIDTH-1:0] rdata_o,

    // external data memory
    output logic                  dmem_cyc_o,
    output logic                  dmem_stb_o,
    output logic                  dmem_we_o,
    output logic [ADDR_WIDTH-1:0] dmem_addr_o,
    output logic [SEL_WIDTH-1:0]  dmem_sel_o,
    output logic [DATA_WIDTH-1:0] dmem_wdata_o,
    input  logic                  dmem_ack_i,
    input  logic [DATA_WIDTH-1:0] dmem_rdata_i,

    // peripherals
    output logic [7:0]            led_status_o,
    output logic                  timer_irq_o
);

    // slave side bus
    logic [NUM_SLAVES-1:0] s_cyc;
    logic [NUM_SLAVES-1:0] s_stb;
    logic                  s_we;
    logic [ADDR_WIDTH-1:0] s_addr;
    logic [SEL_WIDTH-1:0]  s_sel;
    logic [DATA_WIDTH-1:0] s_wdata;
    logic [NUM_SLAVES-1:0] s_ack;
    logic [DATA_WIDTH-1:0] s_rdata [NUM_SLAVES];

    wb_interconnect #(
        .NUM_SLAVES    (NUM_SLAVES),
        .START_ADDRESS (START_ADDRESS),
        .MASK          (MASK)
    ) wb_interconnect_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .sel_i     (sel_i),
        .wdata_i   (wdata_i),
        .ack_o     (ack_o),
        .err_o     (err_o),
        .rdata_o   (rdata_o),
        .s_cyc_o   (s_cyc),
        .s_stb_o   (s_stb),
        .s_we_o    (s_we),
        .s_addr_o  (s_addr),
        .s_sel_o   (s_sel),
        .s_wdata_o (s_wdata),
        .s_ack_i   (s_ack),
        .s_rdata_i (s_rdata)
    );

    // dmem slot goes straight out of the platform
    assign dmem_cyc_o                = s_cyc[DMEM_SLAVE_INDEX];
    assign dmem_stb_o                = s_stb[DMEM_SLAVE_INDEX];
    assign dmem_we_o                 = s_we;
    assign dmem_addr_o               = s_addr;
    assign dmem_sel_o                = s_sel;
    assign dmem_wdata_o              = s_wdata;
    assign s_ack[DMEM_SLAVE_INDEX]   = dmem_ack_i;
    assign s_rdata[DMEM_SLAVE_INDEX] = dmem_rdata_i;

    // timer only decodes its low four address bits
    mtimer mtimer_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .cyc_i       (s_cyc[MTIMER_SLAVE_INDEX]),
        .stb_i       (s_stb[MTIMER_SLAVE_INDEX]),
        .we_i        (s_we),
        .addr_i      (s_addr[3:0]),
        .sel_i       (s_sel),
        .wdata_i     (s_wdata),
        .ack_o       (s_ack[MTIMER_SLAVE_INDEX]),
        .rdata_o     (s_rdata[MTIMER_SLAVE_INDEX]),
        .timer_irq_o (timer_irq_o)
    );

    led_driver led_driver_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cyc_i        (s_cyc[LED_DRIVER_SLAVE_INDEX]),
        .stb_i        (s_stb[LED_DRIVER_SLAVE_INDEX]),
        .we_i         (s_we),
        .sel_i        (s_sel),
        .wdata_i      (s_wdata),
        .ack_o        (s_ack[LED_DRIVER_SLAVE_INDEX]),
        .rdata_o      (s_rdata[LED_DRIVER_SLAVE_INDEX]),
        .led_status_o (led_status_o)
    );

endmodule : yarc_platform

/* source/led_driver.sv */
// 8-bit led status register on the wishbone bus
// written from byte lane 0, read back zero extended, acked one cycle after stb
module led_driver
    import wb_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // bus slave port, single register so no address
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [SEL_WIDTH-1:0]  sel_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic                  ack_o,
    output logic [DATA_WIDTH-1:0] rdata_o,

    // led pins
    output logic [7:0]            led_status_o
);

    logic [7:0] led_q;
    logic       ack_q;
    logic       access;

    // ignore the strobe while the previous ack is out
    assign access = cyc_i && stb_i && !ack_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            // only lane 0 carries the led byte
            if (access && we_i && sel_i[0]) begin
                led_q <= wdata_i[7:0];
            end
        end
    end

    assign ack_o        = ack_q;
    assign rdata_o      = {{(DATA_WIDTH-8){1'b0}}, led_q};
    assign led_status_o = led_q;

endmodule : led_driver

/* source/mtimer.sv */
// risc-v style machine timer on the wishbone bus
// free running 64-bit mtime, writable mtimecmp, irq while mtime >= mtimecmp
// registers are reached through the low four address bits
module mtimer
    import wb_pkg::*;
    import platform_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // bus slave port
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [3:0]            addr_i,
    input  logic [SEL_WIDTH-1:0]  sel_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic                  ack_o,
    output logic [DATA_WIDTH-1:0] rdata_o,

    // interrupt to the core
    output logic                  timer_irq_o
);

    logic [2*DATA_WIDTH-1:0] mtime;
    logic [2*DATA_WIDTH-1:0] mtimecmp;
    logic                    ack_q;
    logic                    irq_q;
    logic [DATA_WIDTH-1:0]   rdata_q;
    logic [DATA_WIDTH-1:0]   rdata_next;
    logic                    access;

    // new access, not the tail of one already acked
    assign access = cyc_i && stb_i && !ack_q;

    // merge write data into a word honoring byte selects
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(
        input logic [DATA_WIDTH-1:0] old_word,
        input logic [DATA_WIDTH-1:0] new_word,
        input logic [SEL_WIDTH-1:0]  sel
    );
        logic [DATA_WIDTH-1:0] res;
        res = old_word;
        for (int b = 0; b < SEL_WIDTH; b++) begin
            if (sel[b]) begin
                res[b*BYTE_WIDTH +: BYTE_WIDTH] = new_word[b*BYTE_WIDTH +: BYTE_WIDTH];
            end
        end
        return res;
    endfunction

    // read mux, word aligned offsets
    always_comb begin
        case (addr_i[3:2])
            MTIME_LO_OFFSET[3:2]:    rdata_next = mtime[DATA_WIDTH-1:0];
            MTIME_HI_OFFSET[3:2]:    rdata_next = mtime[2*DATA_WIDTH-1:DATA_WIDTH];
            MTIMECMP_LO_OFFSET[3:2]: rdata_next = mtimecmp[DATA_WIDTH-1:0];
            default:                 rdata_next = mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH];
        endcase
    end

    // counter, compare register, ack and irq
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime    <= '0;
            mtimecmp <= '1;
            ack_q    <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            // mtime is read only, writes to it just get acked
            mtime <= mtime + 1'b1;
            ack_q <= access;
            irq_q <= mtime >= mtimecmp;
            if (access && we_i) begin
                if (addr_i[3:2] == MTIMECMP_LO_OFFSET[3:2]) begin
                    mtimecmp[DATA_WIDTH-1:0] <=
                        merge_bytes(mtimecmp[DATA_WIDTH-1:0], wdata_i, sel_i);
                end else if (addr_i[3:2] == MTIMECMP_HI_OFFSET[3:2]) begin
                    mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH] <=
                        merge_bytes(mtimecmp[2*DATA_WIDTH-1:DATA_WIDTH], wdata_i, sel_i);
                end
            end
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk_i) begin
        if (access) begin
            rdata_q <= rdata_next;
        end
    end

    assign ack_o       = ack_q;
    assign rdata_o     = rdata_q;
    assign timer_irq_o = irq_q;

endmodule : mtimer

/* source/wb_interconnect.sv */
// single master, multi slave wishbone interconnect
// decodes the address against a mask/base map, routes cyc/stb to the hit slave
// and muxes its response back, unmapped requests get a registered err
module wb_interconnect
    import wb_pkg::*;
#(
    parameter int NUM_SLAVES = 1,
    parameter logic [ADDR_WIDTH-1:0] START_ADDRESS [NUM_SLAVES] = '{default: '0},
    parameter logic [ADDR_WIDTH-1:0] MASK [NUM_SLAVES] = '{default: '0}
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // master side
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [SEL_WIDTH-1:0]  sel_i,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    output logic                  ack_o,
    output logic                  err_o,
    output logic [DATA_WIDTH-1:0] rdata_o,

    // slave side
    output logic [NUM_SLAVES-1:0] s_cyc_o,
    output logic [NUM_SLAVES-1:0] s_stb_o,
    output logic                  s_we_o,
    output logic [ADDR_WIDTH-1:0] s_addr_o,
    output logic [SEL_WIDTH-1:0]  s_sel_o,
    output logic [DATA_WIDTH-1:0] s_wdata_o,
    input  logic [NUM_SLAVES-1:0] s_ack_i,
    input  logic [DATA_WIDTH-1:0] s_rdata_i [NUM_SLAVES]
);

    // one-hot window hit, all zero when unmapped
    logic [NUM_SLAVES-1:0] hit;
    logic                  miss;
    logic                  req;
    logic                  err_q;

    assign req = cyc_i && stb_i;

    // address decode
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            hit[i] = (addr_i & MASK[i]) == START_ADDRESS[i];
        end
    end

    assign miss = ~|hit;

    // only the selected slave sees cycle and strobe
    assign s_cyc_o = cyc_i ? hit : '0;
    assign s_stb_o = req ? hit : '0;

    // payload is broadcast, slaves look at their low address bits only
    assign s_we_o    = we_i;
    assign s_addr_o  = addr_i;
    assign s_sel_o   = sel_i;
    assign s_wdata_o = wdata_i;

    // response mux
    // at most one hit bit is set so an and/or tree is enough
    always_comb begin
        rdata_o = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (hit[i]) begin
                rdata_o = rdata_o | s_rdata_i[i];
            end
        end
    end

    assign ack_o = |(s_ack_i & hit);

    // unmapped access error
    // set one cycle after stb, held one cycle, cleared once stb drops
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else if (!req) begin
            err_q <= 1'b0;
        end else if (miss && !err_q) begin
            err_q <= 1'b1;
        end else begin
            // single cycle pulse even if stb is still up
            err_q <= 1'b0;
        end
    end

    assign err_o = err_q;

endmodule : wb_interconnect

/* source/platform_pkg.sv */
// memory map and peripheral register layout of the platform
// the top level hands the map to the interconnect, the timer uses the offsets
package platform_pkg;

    // slaves behind the interconnect
    parameter int NUM_SLAVES = 3;

    // position of each slave in the interconnect vectors
    parameter int DMEM_SLAVE_INDEX       = 0;
    parameter int MTIMER_SLAVE_INDEX     = 1;
    parameter int LED_DRIVER_SLAVE_INDEX = 2;

    // base address per slave, indexed as above
    parameter logic [31:0] START_ADDRESS [NUM_SLAVES] = '{
        32'h0001_0000,  // dmem
        32'h0002_0000,  // mtimer
        32'h0003_0000   // led driver
    };

    // match masks, a slave hits when (addr & mask) == base
    parameter logic [31:0] MASK [NUM_SLAVES] = '{
        32'hFFFF_C000,  // 16 KiB data memory
        32'hFFFF_FFF0,  // four timer words
        32'hFFFF_FFFC   // single led word
    };

    // timer register offsets inside its window
    parameter logic [3:0] MTIME_LO_OFFSET    = 4'h0;
    parameter logic [3:0] MTIME_HI_OFFSET    = 4'h4;
    parameter logic [3:0] MTIMECMP_LO_OFFSET = 4'h8;
    parameter logic [3:0] MTIMECMP_HI_OFFSET = 4'hC;

endpackage : platform_pkg

/* source/wb_pkg.sv */
// bus geometry shared by every wishbone port in the platform
// imported by the interconnect, the slaves and the top level
package wb_pkg;

    // byte addressed bus
    parameter int ADDR_WIDTH = 32;

    // one word per transfer
    parameter int DATA_WIDTH = 32;

    // one select bit per byte lane
    parameter int SEL_WIDTH = DATA_WIDTH / 8;

    // bits per byte lane
    parameter int BYTE_WIDTH = 8;

endpackage : wb_pkg
